/* Makefile */
TOP = tb_panel_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -Mdir obj_dir -f imsai_panel.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* imsai_panel.f */
src/video_pkg.sv
src/panel_pkg.sv
src/video_timing.sv
src/led_chaser.sv
src/image_memory.sv
src/panel_renderer.sv
src/terminal_text.sv
src/panel_top.sv
tests/panel_model.sv
tests/tb_panel_top.sv

/* src/image_memory.sv */
// Panel image word memory with a byte upload port and a four-phase read port
module image_memory (
    input  logic                  clk36m,
    input  logic                  reset,
    input  panel_pkg::load_t      load,
    input  logic                  req,
    input  panel_pkg::word_addr_t addr,
    output logic                  ack,
    output panel_pkg::word_t      data
);

    typedef enum logic {MEM_IDLE, MEM_ACK} mem_state_e;

    panel_pkg::word_t mem [panel_pkg::IMAGE_WORDS];
    mem_state_e       state;

    ////////////////////////////////////////
    // Upload side
    ////////////////////////////////////////

    // One byte lane per upload, the image survives a reset
    always_ff @(posedge clk36m) begin
        if (load.valid) begin
            mem[load.addr[11:2]][load.addr[1:0]*8 +: 8] <= load.data;
        end
    end

    ////////////////////////////////////////
    // Read handshake
    ////////////////////////////////////////

    // An upload owns the array in its cycle, so the read waits behind it
    always_ff @(posedge clk36m) begin
        if (reset) begin
            state <= MEM_IDLE;
        end else begin
            case (state)
                MEM_IDLE: begin
                    if (req && !load.valid) begin
                        state <= MEM_ACK;
                    end
                end
                MEM_ACK: begin
                    if (!req) begin
                        state <= MEM_IDLE;
                    end
                end
                default: state <= MEM_IDLE;
            endcase
        end
    end

    // Read data is captured once and held while ack is high
    always_ff @(posedge clk36m) begin
        if (state == MEM_IDLE && req && !load.valid) begin
            data <= mem[addr];
        end
    end

    assign ack = (state == MEM_ACK);

endmodule

/* src/led_chaser.sv */
// Step timer and one-hot chaser that walks a lit LED along the row
module led_chaser #(
    parameter int LED_COUNT   = 16,
    parameter int STEP_CYCLES = 4480
) (
    input  logic                 clk36m,
    input  logic                 reset,
    output logic [LED_COUNT-1:0] lit
);

    localparam int STEP_W = $clog2(STEP_CYCLES + 1);

    logic [STEP_W-1:0] step_cnt;
    logic              step;

    // Counting 0 to STEP_CYCLES-1 gives one step every STEP_CYCLES clocks
    assign step = (step_cnt == STEP_W'(STEP_CYCLES - 1));

    always_ff @(posedge clk36m) begin
        if (reset) begin
            step_cnt <= '0;
            lit      <= LED_COUNT'(1);
        end else begin
            step_cnt <= step ? '0 : step_cnt + STEP_W'(1);
            if (step) begin
                // Rotate so the top LED hands over to LED 0
                lit <= {lit[LED_COUNT-2:0], lit[LED_COUNT-1]};
            end
            // Never leave the row dark
            if (lit == '0) begin
                lit <= LED_COUNT'(1);
            end
        end
    end

endmodule

/* src/panel_pkg.sv */
// Image memory word types, upload port, keyboard event record and fetch states
package panel_pkg;

    // Eight 4-bit intensities, lowest column in the lowest nibble
    typedef logic [31:0] word_t;
    typedef logic [9:0]  word_addr_t;
    typedef logic [11:0] byte_addr_t;
    typedef logic [7:0]  data_byte_t;

    localparam int IMAGE_WORDS = 2 ** $bits(word_addr_t);

    // Upload port, address bits 1..0 pick the byte lane
    typedef struct packed {
        logic       valid;
        byte_addr_t addr;
        data_byte_t data;
    } load_t;

    // Key event grouped as strobe, pressed, extended, code
    typedef struct packed {
        logic       strobe;
        logic       pressed;
        logic       extended;
        logic [7:0] code;
    } key_event_t;

    localparam logic [7:0] KEY_CR     = 8'h0D;
    localparam logic [7:0] CHAR_SPACE = 8'h20;

    typedef enum logic [1:0] {IDLE, REQ, WAIT_DROP} fetch_state_e;

endpackage

/* src/panel_renderer.sv */
// Image word prefetch, nibble unpacking to grey and the LED cell overlay
module panel_renderer #(
    parameter int H_ACTIVE  = 64,
    parameter int H_TOTAL   = 80,
    parameter int V_TOTAL   = 56,
    parameter int LED_COUNT = 16,
    parameter int LED_ROW   = 8
) (
    input  logic                  clk36m,
    input  logic                  reset,
    input  video_pkg::beam_t      beam_in,
    input  logic [LED_COUNT-1:0]  lit,
    output logic                  req,
    output panel_pkg::word_addr_t addr,
    input  logic                  ack,
    input  panel_pkg::word_t      data,
    output video_pkg::rgb_t       pixel,
    output video_pkg::beam_t      beam_out
);

    // Words per image line
    localparam int GROUPS = H_ACTIVE / 8;

    panel_pkg::fetch_state_e state;
    panel_pkg::word_t        cur_word;
    panel_pkg::word_t        next_word;

    logic                  line_fetch;
    logic                  line_start;
    logic                  group_end;
    logic                  fetch_start;
    video_pkg::row_t       next_row;
    video_pkg::row_t       fetch_row;
    video_pkg::col_t       fetch_grp;
    panel_pkg::word_addr_t fetch_addr;
    video_pkg::channel_t   shade;
    logic                  led_on;
    int                    led_idx;

    ////////////////////////////////////////
    // Fetch scheduling
    ////////////////////////////////////////

    // First hblank column fetches word 0 of the coming line, the last one
    // swaps it in and fetches word 1, each group end fetches two ahead
    always_comb begin
        line_fetch  = beam_in.hblank && beam_in.col == video_pkg::col_t'(H_ACTIVE);
        line_start  = beam_in.hblank && beam_in.col == video_pkg::col_t'(H_TOTAL - 1);
        group_end   = !beam_in.hblank && !beam_in.vblank && beam_in.col[2:0] == 3'd7;
        next_row    = (beam_in.row == video_pkg::row_t'(V_TOTAL - 1)) ?
                      '0 : beam_in.row + video_pkg::row_t'(1);
        fetch_start = 1'b0;
        fetch_row   = beam_in.row;
        fetch_grp   = '0;
        if (line_fetch) begin
            fetch_start = 1'b1;
            fetch_row   = next_row;
        end else if (line_start) begin
            fetch_start = 1'b1;
            fetch_row   = next_row;
            fetch_grp   = video_pkg::col_t'(1);
        end else if (group_end && int'(beam_in.col[10:3]) + 2 < GROUPS) begin
            fetch_start = 1'b1;
            fetch_grp   = video_pkg::col_t'(beam_in.col[10:3]) + video_pkg::col_t'(2);
        end
        fetch_addr = panel_pkg::word_addr_t'(int'(fetch_row) * GROUPS + int'(fetch_grp));
    end

    // Four-phase request, the new word lands in next_word
    always_ff @(posedge clk36m) begin
        if (reset) begin
            state <= panel_pkg::IDLE;
            req   <= 1'b0;
        end else begin
            case (state)
                panel_pkg::IDLE: begin
                    if (fetch_start) begin
                        req   <= 1'b1;
                        state <= panel_pkg::REQ;
                    end
                end
                panel_pkg::REQ: begin
                    if (ack) begin
                        req   <= 1'b0;
                        state <= panel_pkg::WAIT_DROP;
                    end
                end
                panel_pkg::WAIT_DROP: begin
                    if (!ack) begin
                        state <= panel_pkg::IDLE;
                    end
                end
                default: state <= panel_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk36m) begin
        if (state == panel_pkg::IDLE && fetch_start) begin
            addr <= fetch_addr;
        end
        if (state == panel_pkg::REQ && ack) begin
            next_word <= data;
        end
        if (line_start || group_end) begin
            cur_word <= next_word;
        end
    end

    ////////////////////////////////////////
    // Pixel stage
    ////////////////////////////////////////

    always_comb begin
        shade   = video_pkg::channel_t'(cur_word >> {beam_in.col[2:0], 2'b00});
        led_idx = int'(beam_in.col[10:2]);
        led_on  = 1'b0;
        // LED cells are four columns wide and four rows high
        if (beam_in.row >= video_pkg::row_t'(LED_ROW) &&
            beam_in.row <  video_pkg::row_t'(LED_ROW + 4) && led_idx < LED_COUNT) begin
            led_on = lit[led_idx];
        end
    end

    always_ff @(posedge clk36m) begin
        if (led_on) begin
            pixel <= '{r: 4'hF, g: 4'h0, b: 4'h0};
        end else begin
            pixel <= '{r: shade, g: shade, b: shade};
        end
    end

    always_ff @(posedge clk36m) begin
        if (reset) begin
            beam_out <= video_pkg::BEAM_RESET;
        end else begin
            beam_out <= beam_in;
        end
    end

endmodule

/* src/panel_top.sv */
// Video subsystem top: block instances, panel and terminal split, output blanking
module panel_top #(
    parameter int H_ACTIVE     = 64,
    parameter int H_TOTAL      = 80,
    parameter int V_ACTIVE     = 48,
    parameter int V_TOTAL      = 56,
    parameter int H_SYNC_START = 68,
    parameter int H_SYNC_LEN   = 4,
    parameter int V_SYNC_START = 50,
    parameter int V_SYNC_LEN   = 2,
    parameter int SPLIT_ROW    = 24,
    parameter int LED_COUNT    = 16,
    parameter int LED_ROW      = 8,
    parameter int STEP_CYCLES  = 4480
) (
    input  logic                  clk36m,
    input  logic                  reset,
    input  panel_pkg::load_t      load,
    input  panel_pkg::key_event_t key,
    output video_pkg::rgb_t       rgb,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  hblank,
    output logic                  vblank
);

    video_pkg::beam_t      beam;
    video_pkg::beam_t      beam_d;
    video_pkg::rgb_t       panel_pixel;
    video_pkg::channel_t   text_level;
    logic [LED_COUNT-1:0]  lit;
    logic                  req;
    logic                  ack;
    logic                  text_pixel;
    panel_pkg::word_addr_t addr;
    panel_pkg::word_t      data;

    video_timing #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN)
    ) timing_inst (.clk36m(clk36m), .reset(reset), .beam(beam));

    led_chaser #(.LED_COUNT(LED_COUNT), .STEP_CYCLES(STEP_CYCLES)) chaser_inst (
        .clk36m(clk36m), .reset(reset), .lit(lit));

    image_memory memory_inst (
        .clk36m(clk36m), .reset(reset), .load(load),
        .req(req), .addr(addr), .ack(ack), .data(data));

    panel_renderer #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL),
        .LED_COUNT(LED_COUNT), .LED_ROW(LED_ROW)
    ) renderer_inst (
        .clk36m(clk36m), .reset(reset), .beam_in(beam), .lit(lit),
        .req(req), .addr(addr), .ack(ack), .data(data),
        .pixel(panel_pixel), .beam_out(beam_d));

    terminal_text #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .SPLIT_ROW(SPLIT_ROW)) terminal_inst (
        .clk36m(clk36m), .reset(reset), .beam_in(beam), .key(key), .text_pixel(text_pixel));

    // Panel above the split row, terminal below, black in blanking
    assign text_level = text_pixel ? 4'hF : 4'h0;

    always_comb begin
        if (beam_d.hblank || beam_d.vblank) begin
            rgb = '0;
        end else if (beam_d.row < video_pkg::row_t'(SPLIT_ROW)) begin
            rgb = panel_pixel;
        end else begin
            rgb = '{r: text_level, g: text_level, b: text_level};
        end
    end

    assign hsync  = beam_d.hsync;
    assign vsync  = beam_d.vsync;
    assign hblank = beam_d.hblank;
    assign vblank = beam_d.vblank;

endmodule

/* src/terminal_text.sv */
// Terminal character buffer fed by key events and its one-bit glyph generator
module terminal_text #(
    parameter int H_ACTIVE  = 64,
    parameter int V_ACTIVE  = 48,
    parameter int SPLIT_ROW = 24
) (
    input  logic                  clk36m,
    input  logic                  reset,
    input  video_pkg::beam_t      beam_in,
    input  panel_pkg::key_event_t key,
    output logic                  text_pixel
);

    localparam int COLS   = H_ACTIVE / 8;
    localparam int LINES  = (V_ACTIVE - SPLIT_ROW) / 8;
    localparam int CELLS  = COLS * LINES;
    localparam int COL_W  = $clog2(COLS);
    localparam int LINE_W = $clog2(LINES);
    localparam int CELL_W = $clog2(CELLS);

    logic [7:0]        text_buf [CELLS];
    logic [COL_W-1:0]  cur_col;
    logic [LINE_W-1:0] cur_line;
    logic [CELL_W-1:0] wr_cell;
    logic [CELL_W-1:0] rd_cell;
    logic              key_write;
    logic              col_last;
    logic              line_last;
    video_pkg::row_t   text_row;
    logic              in_text;
    logic [7:0]        glyph;
    logic [2:0]        cell_x;
    logic [2:0]        cell_y;

    ////////////////////////////////////////
    // Key input and cursor
    ////////////////////////////////////////

    // Releases and extended keys leave the buffer alone
    assign key_write = key.strobe && key.pressed && !key.extended;
    assign col_last  = (cur_col == COL_W'(COLS - 1));
    assign line_last = (cur_line == LINE_W'(LINES - 1));
    assign wr_cell   = CELL_W'(int'(cur_line) * COLS + int'(cur_col));

    always_ff @(posedge clk36m) begin
        if (reset) begin
            cur_col  <= '0;
            cur_line <= '0;
            for (int i = 0; i < CELLS; i++) begin
                text_buf[i] <= panel_pkg::CHAR_SPACE;
            end
        end else if (key_write) begin
            if (key.code == panel_pkg::KEY_CR) begin
                cur_col  <= '0;
                cur_line <= line_last ? '0 : cur_line + LINE_W'(1);
            end else begin
                text_buf[wr_cell] <= key.code;
                cur_col           <= col_last ? '0 : cur_col + COL_W'(1);
                // Past the last cell the cursor goes back to cell 0
                if (col_last) begin
                    cur_line <= line_last ? '0 : cur_line + LINE_W'(1);
                end
            end
        end
    end

    ////////////////////////////////////////
    // Glyph generator
    ////////////////////////////////////////

    always_comb begin
        text_row = beam_in.row - video_pkg::row_t'(SPLIT_ROW);
        in_text  = !beam_in.hblank && !beam_in.vblank &&
                   beam_in.row >= video_pkg::row_t'(SPLIT_ROW);
        rd_cell  = CELL_W'(int'(text_row[9:3]) * COLS + int'(beam_in.col[10:3]));
        cell_x   = beam_in.col[2:0];
        cell_y   = text_row[2:0];
        glyph    = in_text ? text_buf[rd_cell] : panel_pkg::CHAR_SPACE;
    end

    // Code bits drawn on cell rows 1 to 6, bit 7 at the left edge
    always_ff @(posedge clk36m) begin
        text_pixel <= in_text && cell_y != 3'd0 && cell_y != 3'd7 &&
                      glyph[3'd7 - cell_x];
    end

endmodule

/* src/video_pkg.sv */
// Raster count types, colour types and the beam record of the video pipeline
package video_pkg;

    // One colour channel of the 12-bit output
    typedef logic [3:0] channel_t;

    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } rgb_t;

    typedef logic [10:0] col_t;
    typedef logic [9:0]  row_t;

    // Beam state that travels with the pixels, 25 bits
    typedef struct packed {
        col_t col;
        row_t row;
        logic hsync;
        logic vsync;
        logic hblank;
        logic vblank;
    } beam_t;

    // Beam value while in reset: syncs low, both blanks high
    localparam beam_t BEAM_RESET = '{col: '0, row: '0, hsync: 1'b0, vsync: 1'b0,
                                     hblank: 1'b1, vblank: 1'b1};

endpackage

/* src/video_timing.sv */
// Raster counters producing the registered beam position, sync and blanking
module video_timing #(
    parameter int H_ACTIVE     = 64,
    parameter int H_TOTAL      = 80,
    parameter int V_ACTIVE     = 48,
    parameter int V_TOTAL      = 56,
    parameter int H_SYNC_START = 68,
    parameter int H_SYNC_LEN   = 4,
    parameter int V_SYNC_START = 50,
    parameter int V_SYNC_LEN   = 2
) (
    input  logic               clk36m,
    input  logic               reset,
    output video_pkg::beam_t   beam
);

    video_pkg::col_t h_cnt;
    video_pkg::row_t v_cnt;

    logic h_last;
    logic v_last;

    assign h_last = (h_cnt == video_pkg::col_t'(H_TOTAL - 1));
    assign v_last = (v_cnt == video_pkg::row_t'(V_TOTAL - 1));

    // Free-running counters, the row steps at the end of each line
    always_ff @(posedge clk36m) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            h_cnt <= h_last ? '0 : h_cnt + video_pkg::col_t'(1);
            if (h_last) begin
                v_cnt <= v_last ? '0 : v_cnt + video_pkg::row_t'(1);
            end
        end
    end

    // Decode against the raster parameters, one cycle behind the counters
    always_ff @(posedge clk36m) begin
        if (reset) begin
            beam <= video_pkg::BEAM_RESET;
        end else begin
            beam.col    <= h_cnt;
            beam.row    <= v_cnt;
            beam.hsync  <= (h_cnt >= video_pkg::col_t'(H_SYNC_START)) &&
                           (h_cnt <  video_pkg::col_t'(H_SYNC_START + H_SYNC_LEN));
            beam.vsync  <= (v_cnt >= video_pkg::row_t'(V_SYNC_START)) &&
                           (v_cnt <  video_pkg::row_t'(V_SYNC_START + V_SYNC_LEN));
            beam.hblank <= (h_cnt >= video_pkg::col_t'(H_ACTIVE));
            beam.vblank <= (v_cnt >= video_pkg::row_t'(V_ACTIVE));
        end
    end

endmodule

/* tests/panel_model.sv */
// Reference model of the panel image, LED overlay, terminal buffer and expected pixels
package panel_model;

    // Small raster used in simulation
    localparam int H_ACTIVE     = 64;
    localparam int H_TOTAL      = 80;
    localparam int V_ACTIVE     = 48;
    localparam int V_TOTAL      = 56;
    localparam int H_SYNC_START = 68;
    localparam int H_SYNC_LEN   = 4;
    localparam int V_SYNC_START = 50;
    localparam int V_SYNC_LEN   = 2;
    localparam int SPLIT_ROW    = 24;
    localparam int LED_COUNT    = 16;
    localparam int LED_ROW      = 8;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

    localparam int IMAGE_BYTES = 4096;
    localparam int TEXT_COLS   = H_ACTIVE / 8;
    localparam int TEXT_LINES  = (V_ACTIVE - SPLIT_ROW) / 8;

    logic [7:0] image [IMAGE_BYTES];
    logic [7:0] text [TEXT_COLS * TEXT_LINES];
    int         cur_col;
    int         cur_line;

    function automatic void clear_text();
        for (int i = 0; i < TEXT_COLS * TEXT_LINES; i++) begin
            text[i] = 8'h20;
        end
        cur_col  = 0;
        cur_line = 0;
    endfunction

    // Only pressed, non-extended keys reach the buffer
    function automatic void key_event(logic pressed, logic extended, logic [7:0] code);
        if (pressed && !extended) begin
            if (code == 8'h0D) begin
                cur_col  = 0;
                cur_line = (cur_line + 1) % TEXT_LINES;
            end else begin
                text[cur_line * TEXT_COLS + cur_col] = code;
                cur_col = cur_col + 1;
                if (cur_col == TEXT_COLS) begin
                    cur_col  = 0;
                    cur_line = (cur_line + 1) % TEXT_LINES;
                end
            end
        end
    endfunction

    function automatic logic in_led_cell(int row, int col);
        return row >= LED_ROW && row < LED_ROW + 4 && col / 4 < LED_COUNT;
    endfunction

    // Eight pixels per word, four bytes per word, low nibble first
    function automatic logic [3:0] nibble(int row, int col);
        logic [7:0] b;
        b = image[(row * TEXT_COLS + col / 8) * 4 + (col % 8) / 2];
        return (col % 2 == 1) ? b[7:4] : b[3:0];
    endfunction

    function automatic logic [11:0] panel_pixel(int row, int col, int led);
        logic [3:0] n;
        n = nibble(row, col);
        if (in_led_cell(row, col) && col / 4 == led) begin
            return 12'hF00;
        end
        return {n, n, n};
    endfunction

    // Cell rows 0 and 7 stay dark, bit 7 of the code is the left pixel
    function automatic logic [11:0] text_pixel(int row, int col);
        int         tr;
        int         y;
        int         x;
        logic [7:0] code;
        tr   = row - SPLIT_ROW;
        y    = tr % 8;
        x    = col % 8;
        code = text[(tr / 8) * TEXT_COLS + col / 8];
        if (y != 0 && y != 7 && code[7 - x]) begin
            return 12'hFFF;
        end
        return 12'h000;
    endfunction

endpackage

/* tests/tb_panel_top.sv */
// Clock, reset, random stimulus, frame capture, checks and watchdog for panel_top
module tb_panel_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_ACTIVE   = panel_model::H_ACTIVE;
    localparam int V_ACTIVE   = panel_model::V_ACTIVE;
    localparam int SPLIT_ROW  = panel_model::SPLIT_ROW;
    localparam int FRAME      = panel_model::FRAME_CYCLES;
    localparam int LED_FRAMES = panel_model::LED_COUNT + 1;
    localparam int KEY_EVENTS = 80;

    // Frames spent on upload, raster, image, LED walk, terminal and second reset
    localparam int FRAMES_USED = 1 + 3 + 2 + (LED_FRAMES + 1) + 3 + 2;
    localparam int LIMIT_NS    = (FRAMES_USED + 4) * FRAME * 4;

    logic                  clk36m;
    logic                  reset;
    panel_pkg::load_t      load;
    panel_pkg::key_event_t key;
    video_pkg::rgb_t       rgb;
    logic                  hsync;
    logic                  vsync;
    logic                  hblank;
    logic                  vblank;

    logic prev_hsync;
    logic prev_vsync;
    logic prev_hblank;
    logic prev_vblank;
    int   cycle_no;
    int   frame_no;
    int   captured_frame;

    logic [11:0] frame_buf [V_ACTIVE][H_ACTIVE];

    string test_name;
    int    test_errors;
    int    total_errors;
    int    tests_run;
    int    tests_failed;

    panel_top #(
        .H_ACTIVE(panel_model::H_ACTIVE), .H_TOTAL(panel_model::H_TOTAL),
        .V_ACTIVE(panel_model::V_ACTIVE), .V_TOTAL(panel_model::V_TOTAL),
        .H_SYNC_START(panel_model::H_SYNC_START), .H_SYNC_LEN(panel_model::H_SYNC_LEN),
        .V_SYNC_START(panel_model::V_SYNC_START), .V_SYNC_LEN(panel_model::V_SYNC_LEN),
        .SPLIT_ROW(panel_model::SPLIT_ROW), .LED_COUNT(panel_model::LED_COUNT),
        .LED_ROW(panel_model::LED_ROW), .STEP_CYCLES(FRAME)
    ) panel_top_inst (
        .clk36m(clk36m), .reset(reset), .load(load), .key(key), .rgb(rgb),
        .hsync(hsync), .vsync(vsync), .hblank(hblank), .vblank(vblank));

    initial begin
        clk36m = 1'b0;
        forever #2 clk36m = ~clk36m;
    end

    ////////////////////////////////////////
    // Cycle stepping and checks
    ////////////////////////////////////////

    // Outputs are sampled and inputs driven 1 ns after each rising edge
    task automatic tick();
        prev_hsync  = hsync;
        prev_vsync  = vsync;
        prev_hblank = hblank;
        prev_vblank = vblank;
        @(posedge clk36m);
        #1;
        cycle_no++;
        if (reset) begin
            frame_no = -1;
        end else if (prev_vblank && !vblank) begin
            frame_no++;
        end
    endtask

    task automatic check_value(string what, int expected, int actual);
        assert (expected == actual) else begin
            $display("** Error %s: %s expected %0h, actual %0h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic begin_test(string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d errors", test_name, test_errors);
            tests_failed++;
            total_errors += test_errors;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic pulse_reset();
        reset = 1'b1;
        repeat (5) tick();
        reset = 1'b0;
        panel_model::clear_text();
    endtask

    // Whole byte space gets random data while reset is high
    task automatic upload_image();
        for (int a = 0; a < panel_model::IMAGE_BYTES; a++) begin
            panel_model::image[a] = 8'($urandom);
            load.valid = 1'b1;
            load.addr  = 12'(a);
            load.data  = panel_model::image[a];
            tick();
        end
        load = '0;
    endtask

    task automatic send_key(logic pressed, logic extended, logic [7:0] code);
        key = '{strobe: 1'b1, pressed: pressed, extended: extended, code: code};
        panel_model::key_event(pressed, extended, code);
        tick();
        key = '0;
        repeat ($urandom_range(2)) tick();
    endtask

    ////////////////////////////////////////
    // Frame capture and comparison
    ////////////////////////////////////////

    task automatic capture_frame();
        int row;
        int col;
        tick();
        while (!(prev_vblank && !vblank)) begin
            tick();
        end
        captured_frame = frame_no;
        row = 0;
        col = 0;
        while (!vblank) begin
            if (!hblank) begin
                if (row < V_ACTIVE && col < H_ACTIVE) begin
                    frame_buf[row][col] = rgb;
                end
                col++;
            end else if (!prev_hblank) begin
                check_value("active cycles in line", H_ACTIVE, col);
                row++;
                col = 0;
            end
            tick();
        end
        check_value("active lines in frame", V_ACTIVE, row);
    endtask

    // Row 0 of the first frame after reset was never prefetched
    task automatic check_panel(logic with_leds);
        int first_row;
        int led;
        first_row = (captured_frame == 0) ? 1 : 0;
        led       = captured_frame % panel_model::LED_COUNT;
        for (int r = first_row; r < SPLIT_ROW; r++) begin
            for (int c = 0; c < H_ACTIVE; c++) begin
                if (with_leds || !panel_model::in_led_cell(r, c)) begin
                    check_value($sformatf("panel row %0d col %0d", r, c),
                                panel_model::panel_pixel(r, c, led), frame_buf[r][c]);
                end
            end
        end
    endtask

    task automatic check_text();
        for (int r = SPLIT_ROW; r < V_ACTIVE; r++) begin
            for (int c = 0; c < H_ACTIVE; c++) begin
                check_value($sformatf("text row %0d col %0d", r, c),
                            panel_model::text_pixel(r, c), frame_buf[r][c]);
            end
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic run_raster_test();
        int last_h;
        int last_v;
        int active;
        int lines;
        int frames;
        begin_test("raster");
        last_h = -1;
        last_v = -1;
        active = 0;
        lines  = -1;
        frames = 0;
        while (frames < 3) begin
            tick();
            if (hsync && !prev_hsync) begin
                if (last_h >= 0) begin
                    check_value("hsync period", panel_model::H_TOTAL, cycle_no - last_h);
                end
                last_h = cycle_no;
            end
            if (vsync && !prev_vsync) begin
                if (last_v >= 0) begin
                    check_value("vsync period", FRAME, cycle_no - last_v);
                end
                last_v = cycle_no;
            end
            if (hblank || vblank) begin
                check_value("rgb in blanking", 0, rgb);
            end
            if (prev_vblank && !vblank) begin
                lines = 0;
            end
            if (lines >= 0 && !hblank && !vblank) begin
                active++;
            end
            if (hblank && !prev_hblank && active > 0) begin
                check_value("active cycles in line", H_ACTIVE, active);
                active = 0;
                lines++;
            end
            if (vblank && !prev_vblank && lines >= 0) begin
                check_value("active lines in frame", V_ACTIVE, lines);
                frames++;
            end
        end
        end_test();
    endtask

    task automatic run_led_test();
        begin_test("led chaser");
        for (int i = 0; i < LED_FRAMES; i++) begin
            capture_frame();
            check_panel(1'b1);
        end
        end_test();
    endtask

    // Sends mostly printable codes with some returns, releases and extended keys
    task automatic run_terminal_test();
        int         kind;
        logic [7:0] code;
        begin_test("terminal");
        for (int i = 0; i < KEY_EVENTS; i++) begin
            kind = $urandom_range(99);
            code = 8'($urandom_range(8'h7E, 8'h21));
            if (kind < 60) begin
                send_key(1'b1, 1'b0, code);
            end else if (kind < 70) begin
                send_key(1'b1, 1'b0, 8'h0D);
            end else if (kind < 85) begin
                send_key(1'b0, 1'b0, code);
            end else begin
                send_key(1'b1, 1'b1, code);
            end
        end
        capture_frame();
        check_text();
        end_test();
    endtask

    initial begin
        #LIMIT_NS;
        $display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(73));
        reset        = 1'b1;
        load         = '0;
        key          = '0;
        cycle_no     = 0;
        frame_no     = -1;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        tick();
        upload_image();
        pulse_reset();

        run_raster_test();

        begin_test("panel image");
        capture_frame();
        check_panel(1'b0);
        end_test();

        run_led_test();
        run_terminal_test();

        // The buffer returns to spaces and the chaser to LED 0 while the image stays
        begin_test("second reset");
        pulse_reset();
        capture_frame();
        check_panel(1'b1);
        check_text();
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
